// File: Bender.yml
package:
  name: rv32_pipeline

sources:
  - include_dirs:
      - design
    files:
      - design/pipeline_pkg.sv
      - design/stage_register.sv
      - design/fetch_unit.sv
      - design/decode_stage.sv
      - design/execute_stage.sv
      - design/memory_stage.sv
      - design/hazard_unit.sv
      - design/pipeline.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/pipeline_checker.sv
      - verif/pipeline_tb.sv

// File: build.f
+incdir+design
design/pipeline_pkg.sv
design/stage_register.sv
design/fetch_unit.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/hazard_unit.sv
design/pipeline.sv
verif/pipeline_checker.sv
verif/pipeline_tb.sv

// File: design/decode_stage.sv
//////////////////////////////
// Decode and register file
//////////////////////////////
`include "pipeline_macros.svh"

module decode_stage (
    input  logic                             clock,
    input  logic                             reset,
    input  pipeline_pkg::fetch_payload_t     fetch_q,
    input  pipeline_pkg::writeback_payload_t wb,
    output pipeline_pkg::decode_payload_t    decode_payload
);

    logic [`XLEN-1:0]      reg_file [`REG_COUNT];
    logic                  wb_write;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [`REG_IDX_W-1:0] rd;
    logic [`REG_IDX_W-1:0] rs1;
    logic [`REG_IDX_W-1:0] rs2;
    logic [`XLEN-1:0]      i_imm;
    logic [`XLEN-1:0]      s_imm;

    //////////////////////////////
    // Register file
    //////////////////////////////
    assign wb_write = wb.valid && (wb.dest_idx != `ZERO_REG);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                reg_file[i] <= '0;  // Architectural state starts cleared
            end
        end else if (wb_write) begin
            reg_file[wb.dest_idx] <= wb.result;
        end
    end

    // Read port with write-through of the same-cycle writeback
    function automatic logic [`XLEN-1:0] read_reg(input logic [`REG_IDX_W-1:0] idx);
        if (wb_write && (wb.dest_idx == idx)) begin
            return wb.result;
        end
        return reg_file[idx];
    endfunction

    //////////////////////////////
    // Field decode
    //////////////////////////////
    assign opcode = fetch_q.inst[6:0];
    assign rd     = fetch_q.inst[11:7];
    assign funct3 = fetch_q.inst[14:12];
    assign rs1    = fetch_q.inst[19:15];
    assign rs2    = fetch_q.inst[24:20];
    assign funct7 = fetch_q.inst[31:25];
    assign i_imm  = {{20{fetch_q.inst[31]}}, fetch_q.inst[31:20]};
    assign s_imm  = {{20{fetch_q.inst[31]}}, fetch_q.inst[31:25], fetch_q.inst[11:7]};

    always_comb begin
        decode_payload       = '0;  // Unsupported: no sources, no write, no access
        decode_payload.valid = fetch_q.valid;
        decode_payload.inst  = fetch_q.inst;
        decode_payload.npc   = fetch_q.npc;
        if (fetch_q.valid) begin
            case (opcode)
                `OP_REG: begin
                    decode_payload.rs1_idx  = rs1;
                    decode_payload.rs2_idx  = rs2;
                    decode_payload.dest_idx = rd;
                    case ({funct7, funct3})
                        {`FUNCT7_BASE, `FUNCT3_ADD}: decode_payload.alu_op = pipeline_pkg::alu_add;
                        {`FUNCT7_SUB,  `FUNCT3_SUB}: decode_payload.alu_op = pipeline_pkg::alu_sub;
                        {`FUNCT7_BASE, `FUNCT3_AND}: decode_payload.alu_op = pipeline_pkg::alu_and;
                        {`FUNCT7_BASE, `FUNCT3_OR}:  decode_payload.alu_op = pipeline_pkg::alu_or;
                        {`FUNCT7_BASE, `FUNCT3_XOR}: decode_payload.alu_op = pipeline_pkg::alu_xor;
                        default: begin
                            decode_payload.rs1_idx  = `ZERO_REG;
                            decode_payload.rs2_idx  = `ZERO_REG;
                            decode_payload.dest_idx = `ZERO_REG;
                        end
                    endcase
                end
                `OP_IMM: if (funct3 == `FUNCT3_ADD) begin  // ADDI only
                    decode_payload.rs1_idx  = rs1;
                    decode_payload.dest_idx = rd;
                    decode_payload.imm      = i_imm;
                    decode_payload.b_is_imm = 1'b1;
                end
                `OP_LOAD: if (funct3 == `FUNCT3_WORD) begin
                    decode_payload.rs1_idx  = rs1;
                    decode_payload.dest_idx = rd;
                    decode_payload.imm      = i_imm;
                    decode_payload.b_is_imm = 1'b1;
                    decode_payload.mem_read = 1'b1;
                end
                `OP_STORE: if (funct3 == `FUNCT3_WORD) begin
                    decode_payload.rs1_idx   = rs1;
                    decode_payload.rs2_idx   = rs2;  // Store data
                    decode_payload.imm       = s_imm;
                    decode_payload.b_is_imm  = 1'b1;
                    decode_payload.mem_write = 1'b1;
                end
                default: ;
            endcase
        end
        decode_payload.rs1_value = read_reg(decode_payload.rs1_idx);
        decode_payload.rs2_value = read_reg(decode_payload.rs2_idx);
    end

endmodule

// File: design/execute_stage.sv
//////////////////////////////
// Execute stage
//////////////////////////////
`include "pipeline_macros.svh"

module execute_stage (
    input  pipeline_pkg::decode_payload_t  decode_q,
    input  pipeline_pkg::forward_sel_t     forward_a,
    input  pipeline_pkg::forward_sel_t     forward_b,
    input  logic [`XLEN-1:0]               mem_result,  // ALU result in memory stage
    input  logic [`XLEN-1:0]               wb_result,   // Writeback data
    output pipeline_pkg::execute_payload_t execute_payload
);

    logic [`XLEN-1:0] rs1_fwd;
    logic [`XLEN-1:0] rs2_fwd;
    logic [`XLEN-1:0] operand_b;
    logic [`XLEN-1:0] alu_result;

    function automatic logic [`XLEN-1:0] select_operand(
        input pipeline_pkg::forward_sel_t sel,
        input logic [`XLEN-1:0]           reg_value
    );
        case (sel)
            pipeline_pkg::fwd_mem: return mem_result;
            pipeline_pkg::fwd_wb:  return wb_result;
            default:               return reg_value;
        endcase
    endfunction

    always_comb begin
        rs1_fwd = select_operand(forward_a, decode_q.rs1_value);
        rs2_fwd = select_operand(forward_b, decode_q.rs2_value);
    end

    assign operand_b = decode_q.b_is_imm ? decode_q.imm : rs2_fwd;

    // Loads and stores decode as add, giving the address
    always_comb begin
        case (decode_q.alu_op)
            pipeline_pkg::alu_sub: alu_result = rs1_fwd - operand_b;
            pipeline_pkg::alu_and: alu_result = rs1_fwd & operand_b;
            pipeline_pkg::alu_or:  alu_result = rs1_fwd | operand_b;
            pipeline_pkg::alu_xor: alu_result = rs1_fwd ^ operand_b;
            default:               alu_result = rs1_fwd + operand_b;
        endcase
    end

    always_comb begin
        execute_payload.valid      = decode_q.valid;
        execute_payload.inst       = decode_q.inst;
        execute_payload.npc        = decode_q.npc;
        execute_payload.alu_result = alu_result;
        execute_payload.store_data = rs2_fwd;
        execute_payload.dest_idx   = decode_q.dest_idx;
        execute_payload.mem_read   = decode_q.mem_read;
        execute_payload.mem_write  = decode_q.mem_write;
    end

endmodule

// File: design/fetch_unit.sv
//////////////////////////////
// Instruction fetch
//////////////////////////////
`include "pipeline_macros.svh"

module fetch_unit (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        fetch_valid,
    input  logic                        stall,
    input  logic [`XLEN-1:0]            mem_rdata,
    output logic [`XLEN-1:0]            fetch_pc,
    output pipeline_pkg::fetch_payload_t fetch_payload
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] next_pc;

    assign next_pc = pc + `XLEN'd4;

    // PC counter, advances only when the fetched word is taken
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (fetch_valid && !stall) begin
            pc <= next_pc;
        end
    end

    assign fetch_pc = pc;

    always_comb begin
        fetch_payload.valid = fetch_valid;  // Bus lost to a data access otherwise
        fetch_payload.pc    = pc;
        fetch_payload.npc   = next_pc;
        fetch_payload.inst  = mem_rdata;
    end

endmodule

// File: design/hazard_unit.sv
//////////////////////////////
// Hazard and forwarding
//////////////////////////////
`include "pipeline_macros.svh"

module hazard_unit (
    input  logic                             clock,
    input  logic                             reset,
    input  pipeline_pkg::decode_payload_t    decode_payload,
    input  pipeline_pkg::execute_payload_t   execute_payload,
    input  pipeline_pkg::writeback_payload_t writeback_payload,
    input  pipeline_pkg::decode_payload_t    decode_q,        // Instruction in execute
    output logic                             fetch_valid,
    output logic                             stall,
    output pipeline_pkg::forward_sel_t       forward_a,
    output pipeline_pkg::forward_sel_t       forward_b
);

    logic data_access;

    // Load or store in execute takes the bus next cycle
    assign data_access = execute_payload.valid
                       && (execute_payload.mem_read || execute_payload.mem_write);

    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_valid <= 1'b1;
        end else begin
            fetch_valid <= !data_access;
        end
    end

    // Load-use: result not ready until the memory stage
    assign stall = decode_q.valid && decode_q.mem_read
                 && (decode_q.dest_idx != `ZERO_REG)
                 && ((decode_q.dest_idx == decode_payload.rs1_idx)
                  || (decode_q.dest_idx == decode_payload.rs2_idx));

    // Nearest producer wins, x0 never forwards
    function automatic pipeline_pkg::forward_sel_t pick_source(
        input logic [`REG_IDX_W-1:0] src
    );
        if (src == `ZERO_REG) begin
            return pipeline_pkg::fwd_reg;
        end else if (execute_payload.valid && (execute_payload.dest_idx == src)) begin
            return pipeline_pkg::fwd_mem;
        end else if (writeback_payload.valid && (writeback_payload.dest_idx == src)) begin
            return pipeline_pkg::fwd_wb;
        end
        return pipeline_pkg::fwd_reg;
    endfunction

    // Selects apply once the producers have moved one stage on
    always_ff @(posedge clock) begin
        if (reset) begin
            forward_a <= pipeline_pkg::fwd_reg;
            forward_b <= pipeline_pkg::fwd_reg;
        end else begin
            forward_a <= pick_source(decode_payload.rs1_idx);
            forward_b <= pick_source(decode_payload.rs2_idx);
        end
    end

endmodule

// File: design/memory_stage.sv
//////////////////////////////
// Memory stage
//////////////////////////////
`include "pipeline_macros.svh"

module memory_stage (
    input  pipeline_pkg::execute_payload_t   execute_q,
    input  logic [`XLEN-1:0]                 fetch_pc,
    input  logic [`XLEN-1:0]                 mem_rdata,
    output pipeline_pkg::mem_request_t       mem_request,
    output pipeline_pkg::writeback_payload_t writeback_payload
);

    logic data_load;
    logic data_store;

    assign data_load  = execute_q.valid && execute_q.mem_read;
    assign data_store = execute_q.valid && execute_q.mem_write;

    // One request per cycle, data access wins over fetch
    always_comb begin
        mem_request.data = execute_q.store_data;
        if (data_load || data_store) begin
            mem_request.command = data_store ? pipeline_pkg::bus_store : pipeline_pkg::bus_load;
            mem_request.addr    = execute_q.alu_result;
        end else begin
            mem_request.command = pipeline_pkg::bus_load;  // Instruction fetch
            mem_request.addr    = fetch_pc;
        end
    end

    always_comb begin
        writeback_payload.valid    = execute_q.valid;
        writeback_payload.inst     = execute_q.inst;
        writeback_payload.npc      = execute_q.npc;
        writeback_payload.result   = data_load ? mem_rdata : execute_q.alu_result;
        writeback_payload.dest_idx = execute_q.dest_idx;
    end

endmodule

// File: design/pipeline.sv
//////////////////////////////
// Five-stage RV32 pipeline
//////////////////////////////
`include "pipeline_macros.svh"

module pipeline (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [`XLEN-1:0]            mem_rdata,    // Same-cycle memory answer
    output pipeline_pkg::mem_request_t  mem_request,
    output pipeline_pkg::commit_t       commit
);

    logic                             fetch_valid;
    logic                             stall;
    pipeline_pkg::forward_sel_t       forward_a;
    pipeline_pkg::forward_sel_t       forward_b;
    logic [`XLEN-1:0]                 fetch_pc;
    pipeline_pkg::fetch_payload_t     fetch_payload, fetch_q;
    pipeline_pkg::decode_payload_t    decode_payload, decode_q;
    pipeline_pkg::execute_payload_t   execute_payload, execute_q;
    pipeline_pkg::writeback_payload_t writeback_payload, writeback_q;

    //////////////////////////////
    // Fetch and decode
    //////////////////////////////
    fetch_unit fetch_unit_0 (
        .clock, .reset, .fetch_valid, .stall, .mem_rdata,
        .fetch_pc, .fetch_payload
    );

    stage_register #(.payload_t(pipeline_pkg::fetch_payload_t)) fetch_reg (
        .clock, .reset,
        .hold   (stall),   // Keep the dependent instruction in decode
        .bubble (1'b0),
        .d      (fetch_payload),
        .q      (fetch_q)
    );

    decode_stage decode_stage_0 (
        .clock, .reset, .fetch_q,
        .wb (writeback_q),
        .decode_payload
    );

    stage_register #(.payload_t(pipeline_pkg::decode_payload_t)) decode_reg (
        .clock, .reset,
        .hold   (1'b0),
        .bubble (stall),   // Bubble behind the load
        .d      (decode_payload),
        .q      (decode_q)
    );

    //////////////////////////////
    // Execute, memory, writeback
    //////////////////////////////
    execute_stage execute_stage_0 (
        .decode_q, .forward_a, .forward_b,
        .mem_result (execute_q.alu_result),
        .wb_result  (writeback_q.result),
        .execute_payload
    );

    stage_register #(.payload_t(pipeline_pkg::execute_payload_t)) execute_reg (
        .clock, .reset, .hold (1'b0), .bubble (1'b0),
        .d (execute_payload), .q (execute_q)
    );

    memory_stage memory_stage_0 (
        .execute_q, .fetch_pc, .mem_rdata, .mem_request, .writeback_payload
    );

    stage_register #(.payload_t(pipeline_pkg::writeback_payload_t)) writeback_reg (
        .clock, .reset, .hold (1'b0), .bubble (1'b0),
        .d (writeback_payload), .q (writeback_q)
    );

    hazard_unit hazard_unit_0 (
        .clock, .reset, .decode_payload, .execute_payload, .writeback_payload,
        .decode_q, .fetch_valid, .stall, .forward_a, .forward_b
    );

    // Retire trace
    always_comb begin
        commit.valid   = writeback_q.valid;
        commit.wr_en   = writeback_q.valid && (writeback_q.dest_idx != `ZERO_REG);
        commit.wr_idx  = writeback_q.dest_idx;
        commit.wr_data = writeback_q.result;
        commit.npc     = writeback_q.npc;
        commit.inst    = writeback_q.inst;
    end

endmodule

// File: design/pipeline_macros.svh
//////////////////////////////
// Pipeline constants
//////////////////////////////
`ifndef PIPELINE_MACROS_SVH
`define PIPELINE_MACROS_SVH

`define XLEN      32           // Data and address width
`define REG_COUNT 32
`define REG_IDX_W 5
`define ZERO_REG  5'd0         // x0, never written
`define RESET_PC  32'h0000_0000

// Major opcodes
`define OP_REG   7'b0110011
`define OP_IMM   7'b0010011
`define OP_LOAD  7'b0000011
`define OP_STORE 7'b0100011

// Funct fields of the supported operations
`define FUNCT3_ADD  3'b000
`define FUNCT3_SUB  3'b000     // Same funct3 as ADD, split by funct7
`define FUNCT3_XOR  3'b100
`define FUNCT3_OR   3'b110
`define FUNCT3_AND  3'b111
`define FUNCT3_WORD 3'b010     // LW and SW
`define FUNCT7_BASE 7'b0000000
`define FUNCT7_SUB  7'b0100000

`endif

// File: design/pipeline_pkg.sv
//////////////////////////////
// Pipeline types
//////////////////////////////
`include "pipeline_macros.svh"

package pipeline_pkg;

    typedef enum logic [1:0] {
        bus_none  = 2'd0,
        bus_load  = 2'd1,
        bus_store = 2'd2
    } bus_command_t;

    // Operand source in execute
    typedef enum logic [1:0] {
        fwd_reg = 2'd0,  // Value read in decode
        fwd_mem = 2'd1,  // ALU result sitting in the memory stage
        fwd_wb  = 2'd2   // Data about to be written back
    } forward_sel_t;

    // Names carry a prefix since and, or, xor are keywords
    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor
    } alu_op_t;

    //////////////////////////////
    // Stage payloads
    //////////////////////////////
    // All zeros means an invalid slot
    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   npc;
        logic [31:0]        inst;
    } fetch_payload_t;

    typedef struct packed {
        logic                  valid;
        logic [31:0]           inst;
        logic [`XLEN-1:0]      npc;
        logic [`XLEN-1:0]      rs1_value;
        logic [`XLEN-1:0]      rs2_value;
        logic [`REG_IDX_W-1:0] rs1_idx;   // ZERO_REG when unused
        logic [`REG_IDX_W-1:0] rs2_idx;
        logic [`XLEN-1:0]      imm;
        logic                  b_is_imm;
        alu_op_t               alu_op;
        logic [`REG_IDX_W-1:0] dest_idx;  // ZERO_REG for no write
        logic                  mem_read;
        logic                  mem_write;
    } decode_payload_t;

    typedef struct packed {
        logic                  valid;
        logic [31:0]           inst;
        logic [`XLEN-1:0]      npc;
        logic [`XLEN-1:0]      alu_result; // Also the load/store address
        logic [`XLEN-1:0]      store_data;
        logic [`REG_IDX_W-1:0] dest_idx;
        logic                  mem_read;
        logic                  mem_write;
    } execute_payload_t;

    typedef struct packed {
        logic                  valid;
        logic [31:0]           inst;
        logic [`XLEN-1:0]      npc;
        logic [`XLEN-1:0]      result;
        logic [`REG_IDX_W-1:0] dest_idx;
    } writeback_payload_t;

    typedef struct packed {
        bus_command_t     command;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] data;
    } mem_request_t;

    typedef struct packed {
        logic                  valid;
        logic                  wr_en;
        logic [`REG_IDX_W-1:0] wr_idx;
        logic [`XLEN-1:0]      wr_data;
        logic [`XLEN-1:0]      npc;
        logic [31:0]           inst;
    } commit_t;

endpackage

// File: design/stage_register.sv
//////////////////////////////
// Pipeline stage register
//////////////////////////////

module stage_register #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     hold,    // Keep current contents
    input  logic     bubble,  // Load an invalid slot
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clock) begin
        if (reset || bubble) begin
            q <= '0;          // Zero payload reads as invalid
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

// File: verif/pipeline_checker.sv
//////////////////////////////
// Commit and bus checker
//////////////////////////////
`include "pipeline_macros.svh"

module pipeline_checker (
    input logic                       clock,
    input logic                       reset,
    input pipeline_pkg::mem_request_t mem_request,
    input logic [`XLEN-1:0]           mem_rdata,
    input pipeline_pkg::commit_t      commit
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          DATA_BASE  = 512;        // Byte address of the data window
    localparam int          DATA_WORDS = 16;
    localparam int          BUS_WORDS  = 256;        // 1 KiB seen through addr[9:2]
    localparam logic [31:0] DATA_SEED  = 32'h5A5A_5A5A;

    int unsigned                error_count = 0;     // Watched by the testbench
    logic [`XLEN-1:0]           shadow_reg [`REG_COUNT];
    logic [`XLEN-1:0]           shadow_mem [DATA_WORDS];
    logic [`XLEN-1:0]           returned_word [BUS_WORDS];  // Memory answer per address
    logic [`XLEN-1:0]           expected_npc;
    pipeline_pkg::mem_request_t last_request;        // Bus one cycle back
    logic [`XLEN-1:0]           inst_addr;
    logic [31:0]                expected_inst;
    logic [6:0]                 opcode;
    logic [2:0]                 funct3;
    logic [6:0]                 funct7;
    logic [`REG_IDX_W-1:0]      rd;
    logic [`XLEN-1:0]           i_imm;
    logic [`XLEN-1:0]           s_imm;
    logic [`XLEN-1:0]           src1;
    logic [`XLEN-1:0]           src2;
    logic [`XLEN-1:0]           data_addr;
    logic [3:0]                 mem_idx;
    logic                       is_alu;
    logic                       is_load;
    logic                       is_store;
    logic                       writes;
    logic [`XLEN-1:0]           expected_data;

    //////////////////////////////
    // Reference model of the commit
    //////////////////////////////
    always_comb begin
        inst_addr     = commit.npc - 32'd4;
        expected_inst = returned_word[inst_addr[9:2]];  // Word the memory gave for this PC
        opcode    = commit.inst[6:0];
        rd        = commit.inst[11:7];
        funct3    = commit.inst[14:12];
        funct7    = commit.inst[31:25];
        i_imm     = {{20{commit.inst[31]}}, commit.inst[31:20]};
        s_imm     = {{20{commit.inst[31]}}, commit.inst[31:25], commit.inst[11:7]};
        src1      = shadow_reg[commit.inst[19:15]];
        src2      = shadow_reg[commit.inst[24:20]];   // Also the store data
        is_load   = (opcode == `OP_LOAD) && (funct3 == `FUNCT3_WORD);
        is_store  = (opcode == `OP_STORE) && (funct3 == `FUNCT3_WORD);
        data_addr = src1 + (is_store ? s_imm : i_imm);
        mem_idx   = 4'((data_addr - DATA_BASE) >> 2);
        is_alu    = 1'b1;
        expected_data = shadow_mem[mem_idx];          // Load result unless ALU below
        if ((opcode == `OP_IMM) && (funct3 == `FUNCT3_ADD)) begin
            expected_data = src1 + i_imm;
        end else if (opcode == `OP_REG) begin
            case ({funct7, funct3})
                {`FUNCT7_BASE, `FUNCT3_ADD}: expected_data = src1 + src2;
                {`FUNCT7_SUB,  `FUNCT3_SUB}: expected_data = src1 - src2;
                {`FUNCT7_BASE, `FUNCT3_AND}: expected_data = src1 & src2;
                {`FUNCT7_BASE, `FUNCT3_OR}:  expected_data = src1 | src2;
                {`FUNCT7_BASE, `FUNCT3_XOR}: expected_data = src1 ^ src2;
                default:                     is_alu = 1'b0;
            endcase
        end else begin
            is_alu = 1'b0;
        end
        writes = (is_alu || is_load) && (rd != `ZERO_REG);
    end

    // Architectural state advances on each commit
    always_ff @(posedge clock) begin
        last_request <= mem_request;
        if (mem_request.command == pipeline_pkg::bus_load) begin
            returned_word[mem_request.addr[9:2]] <= mem_rdata;
        end
        if (reset) begin
            expected_npc <= `RESET_PC + 32'd4;
            for (int r = 0; r < `REG_COUNT; r++) begin
                shadow_reg[r] <= '0;
            end
            for (int w = 0; w < DATA_WORDS; w++) begin
                shadow_mem[w] <= (DATA_BASE + 4 * w) ^ DATA_SEED;  // Same fill as memory
            end
        end else if (commit.valid) begin
            expected_npc <= expected_npc + 32'd4;
            if (writes) begin
                shadow_reg[rd] <= expected_data;
            end
            if (is_store) begin
                shadow_mem[mem_idx] <= src2;
            end
        end
    end

    //////////////////////////////
    // Assertions
    //////////////////////////////
    reset_request: assert property (@(posedge clock)
        $fell(reset) |-> (mem_request.command == pipeline_pkg::bus_load)
                         && (mem_request.addr == `RESET_PC))
    else begin
        error_count++;
        $error("CHECK FAILED at %0t: mem_request expected load at %h got command %0d at %h",
               $time, `RESET_PC, $sampled(mem_request.command), $sampled(mem_request.addr));
    end

    reset_commit: assert property (@(posedge clock) $fell(reset) |-> !commit.valid)
    else begin
        error_count++;
        $error("CHECK FAILED at %0t: commit.valid expected 0 got %0b",
               $time, $sampled(commit.valid));
    end

    // Program order, no gaps
    commit_order: assert property (@(posedge clock) disable iff (reset)
        commit.valid |-> (commit.npc == expected_npc))
    else begin
        error_count++;
        $error("CHECK FAILED at %0t: commit.npc expected %h got %h",
               $time, $sampled(expected_npc), $sampled(commit.npc));
    end

    commit_inst: assert property (@(posedge clock) disable iff (reset)
        commit.valid |-> (commit.inst == expected_inst))
    else begin
        error_count++;
        $error("CHECK FAILED at %0t: commit.inst expected %h got %h",
               $time, $sampled(expected_inst), $sampled(commit.inst));
    end

    commit_write: assert property (@(posedge clock) disable iff (reset)
        (commit.valid && writes) |-> commit.wr_en && (commit.wr_idx == rd)
                                     && (commit.wr_data == expected_data))
    else begin
        error_count++;
        $error("CHECK FAILED at %0t: commit.wr_idx/wr_data expected x%0d %h got x%0d %h",
               $time, $sampled(rd), $sampled(expected_data),
               $sampled(commit.wr_idx), $sampled(commit.wr_data));
    end

    commit_no_write: assert property (@(posedge clock) disable iff (reset)
        (commit.valid && !writes) |-> !commit.wr_en)
    else begin
        error_count++;
        $error("CHECK FAILED at %0t: commit.wr_en expected 0 got 1", $time);
    end

    store_request: assert property (@(posedge clock) disable iff (reset)
        (commit.valid && is_store) |-> (last_request.command == pipeline_pkg::bus_store)
                                       && (last_request.addr == data_addr)
                                       && (last_request.data == src2))
    else begin
        error_count++;
        $error("CHECK FAILED at %0t: mem_request expected store %h to %h got cmd %0d %h to %h",
               $time, $sampled(src2), $sampled(data_addr), $sampled(last_request.command),
               $sampled(last_request.data), $sampled(last_request.addr));
    end

    load_request: assert property (@(posedge clock) disable iff (reset)
        (commit.valid && is_load) |-> (last_request.command == pipeline_pkg::bus_load)
                                      && (last_request.addr == data_addr))
    else begin
        error_count++;
        $error("CHECK FAILED at %0t: mem_request expected load at %h got cmd %0d at %h",
               $time, $sampled(data_addr), $sampled(last_request.command),
               $sampled(last_request.addr));
    end

endmodule

bind pipeline pipeline_checker checker_0 (
    .clock, .reset, .mem_request, .mem_rdata, .commit
);

// File: verif/pipeline_tb.sv
//////////////////////////////
// Pipeline testbench
//////////////////////////////
`include "pipeline_macros.svh"

module pipeline_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLOCK_PERIOD  = 4;
    localparam int RESET_CYCLES  = 4;
    localparam int PROGRAM_WORDS = 64;
    localparam int MEM_WORDS     = 256;     // 1 KiB, word index from addr[9:2]
    localparam int DATA_BASE     = 512;
    localparam int DATA_WORDS    = 16;
    localparam int WATCHDOG_NS   = (PROGRAM_WORDS * 3 + 40) * CLOCK_PERIOD;

    logic                       clock;
    logic                       reset;
    logic [`XLEN-1:0]           mem_rdata;
    pipeline_pkg::mem_request_t mem_request;
    pipeline_pkg::commit_t      commit;
    logic [31:0]                memory [MEM_WORDS];
    int                         commit_count;

    pipeline DUT (
        .clock, .reset, .mem_rdata, .mem_request, .commit
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    //////////////////////////////
    // Memory model
    //////////////////////////////
    assign mem_rdata = memory[mem_request.addr[9:2]];  // Same-cycle answer

    always @(posedge clock) begin
        if (mem_request.command == pipeline_pkg::bus_store) begin
            memory[mem_request.addr[9:2]] <= mem_request.data;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Random program over x0..x7, data window fill
    task automatic load_program();
        logic [31:0] state;
        logic [31:0] inst;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  last_rd;
        logic [11:0] imm;
        logic [11:0] offset;
        state   = 32'd37;
        last_rd = 5'd1;
        for (int a = 0; a < MEM_WORDS; a++) begin
            memory[a] <= '0;                   // Zero words retire without writes
        end
        for (int w = 0; w < DATA_WORDS; w++) begin
            memory[DATA_BASE / 4 + w] <= (DATA_BASE + 4 * w) ^ 32'h5A5A_5A5A;
        end
        for (int i = 0; i < PROGRAM_WORDS; i++) begin
            state  = xorshift(state);
            rd     = {2'b00, state[2:0]};
            rs1    = state[3] ? last_rd : {2'b00, state[6:4]};  // Often the last result
            rs2    = state[7] ? last_rd : {2'b00, state[10:8]};
            imm    = {{4{state[18]}}, state[18:11]};
            offset = 12'(DATA_BASE) + {6'b0, state[14:11], 2'b00};
            case (state[31:29])
                3'd0: inst = {`FUNCT7_BASE, rs2, rs1, `FUNCT3_ADD, rd, `OP_REG};
                3'd1: inst = {`FUNCT7_SUB, rs2, rs1, `FUNCT3_SUB, rd, `OP_REG};
                3'd2: inst = {`FUNCT7_BASE, rs2, rs1, `FUNCT3_AND, rd, `OP_REG};
                3'd3: inst = {`FUNCT7_BASE, rs2, rs1, `FUNCT3_OR, rd, `OP_REG};
                3'd4: inst = {`FUNCT7_BASE, rs2, rs1, `FUNCT3_XOR, rd, `OP_REG};
                3'd5: inst = {imm, rs1, `FUNCT3_ADD, rd, `OP_IMM};
                3'd6: inst = {offset, 5'd0, `FUNCT3_WORD, rd, `OP_LOAD};  // LW rd, off(x0)
                default: inst = {offset[11:5], rs2, 5'd0, `FUNCT3_WORD, offset[4:0], `OP_STORE};
            endcase
            memory[i] <= inst;
            if (state[31:29] != 3'd7) begin
                last_rd = rd;                  // Stores leave no destination
            end
        end
    endtask

    //////////////////////////////
    // Run control
    //////////////////////////////
    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        commit_count = 0;
        load_program();
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        while (commit_count < PROGRAM_WORDS) begin
            @(negedge clock);                  // Commit is settled mid-cycle
            if (commit.valid) begin
                commit_count++;
            end
        end
        @(negedge clock);                      // Checker has sampled the last commit
        if (DUT.checker_0.error_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1, "bound checker reported %0d assertion failures",
                   DUT.checker_0.error_count);
        end
    end

    // First assertion failure ends the run
    initial begin
        wait (DUT.checker_0.error_count != 0);
        $display("TESTBENCH FAILED");
        $fatal(1, "an assertion in the bound checker failed");
    end

    initial begin
        #(WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired after %0d ns with %0d of %0d commits",
               WATCHDOG_NS, commit_count, PROGRAM_WORDS);
    end

endmodule
